// File: mouse_pkg.sv
`default_nettype none

package mouse_pkg;

  // receive word length
  // four report bytes less the parity and stop of the last one
  localparam int c_frame_bits = 42;

  localparam int c_init_len = 7;     // commands sent before reports are taken
  localparam int c_filter_bits = 6;  // msclk sampler length

  // host command bytes without parity
  localparam logic [7:0] c_cmd_enable   = 8'hF4;  // enable data reporting
  localparam logic [7:0] c_cmd_set_rate = 8'hF3;  // next byte is a sample rate
  localparam logic [7:0] c_rate_200     = 8'hC8;
  localparam logic [7:0] c_rate_100     = 8'h64;
  localparam logic [7:0] c_rate_80      = 8'h50;  // 200/100/80 unlocks the wheel

  // shift word as seen once the frame marker has landed
  // bits enter at the msb so the earliest bit ends lowest
  typedef union packed {
    struct packed {
      logic [3:0] wheel_hi;    // upper nibble of byte 4, not used
      logic [3:0] wheel;       // signed wheel delta
      logic       start4;
      logic       stop3;
      logic       par3;
      logic [7:0] dy_byte;     // y movement low bits
      logic       start3;
      logic       stop2;
      logic       par2;
      logic [7:0] dx_byte;     // x movement low bits
      logic       start2;
      logic       stop1;
      logic       par1;
      logic       y_ovf;
      logic       x_ovf;
      logic       y_sign;      // ninth bit of dy
      logic       x_sign;      // ninth bit of dx
      logic       one;         // always set in byte 1
      logic       middle_btn;
      logic       right_btn;
      logic       left_btn;
      logic       start1;      // end marker while run
    } report;
    struct packed {
      logic       ack_par;
      logic [7:0] ack_byte;    // FA from the mouse
      logic       ack_start;
      logic       ack_stop;    // mouse pulls data low in the host stop slot
      logic       cmd_par;
      logic [7:0] cmd_echo;    // our own command as it went out on the line
      logic       cmd_start;   // end marker before run
      logic [20:0] idle;       // still ones from the clear
    } ack;
    logic [c_frame_bits-1:0] raw;  // plain shift register view
  } ps2_frame_t;

endpackage

`default_nettype wire

// File: ps2_line.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_line import mouse_pkg::*; #(
  parameter int c_count_bits = 15  // 15 suits a 25 MHz clock
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        msclk_in,   // sampled mouse clock line
  input  wire        msdat_in,   // sampled mouse data line
  input  wire        run,        // init sequence complete
  input  wire  [8:0] cmd,        // next command with parity on top
  output logic       msclk_oe,   // pull msclk low
  output logic       msdat_oe,   // pull msdat low
  output logic       shift,      // one bit per falling msclk
  output logic       done,       // frame complete and line idle
  output ps2_frame_t frame       // receive word, valid with done
);

  // msclk was high six samples back and low since
  localparam logic [c_filter_bits-1:0] c_fall = {1'b1, {(c_filter_bits - 1){1'b0}}};

  logic [c_filter_bits-1:0] filter;    // msclk history, newest in bit 0
  logic [c_count_bits-1:0]  count;     // cycles since the last bit or timeout
  logic                     endcount;  // line has been quiet long enough
  logic                     req;       // holding msclk low to claim the line
  logic [9:0]               tx;        // start, data, parity going out lsb first
  logic                     endbit;    // marker bit has reached its end slot

  // timeout once the top three count bits are set
  assign endcount = &count[c_count_bits-1 -: 3];

  // no bits are taken while we hold the clock ourselves
  assign shift = ~req & (filter == c_fall);

  // the word is cleared to ones so the first start bit marks the frame end
  // ack frames are shorter than reports and land higher in the word
  assign endbit = run ? ~frame.report.start1 : ~frame.ack.cmd_start;

  assign done = endbit & endcount & ~req;

  // open drain, the lines are only ever pulled low
  assign msclk_oe = req;
  assign msdat_oe = ~tx[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      filter <= '1;  // idle line reads high
    end else begin
      filter <= {filter[c_filter_bits-2:0], msclk_in};
    end
  end

  // idle counter doubles as request length and frame close
  always_ff @(posedge clk) begin
    if (reset || shift || endcount) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // request toggles on each timeout until the sequence is done
  always_ff @(posedge clk) begin
    if (reset || run) begin
      req <= 1'b0;
    end else if (endcount) begin
      req <= ~req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || run) begin
      tx <= '1;                    // data released
    end else if (req) begin
      tx <= {cmd, 1'b0};           // start bit on the line before msclk is freed
    end else if (shift) begin
      tx <= {1'b1, tx[9:1]};       // ones follow so stop and ack slots stay free
    end
  end

  always_ff @(posedge clk) begin
    if (reset || done) begin
      frame.raw <= '1;
    end else if (shift && !endbit) begin
      frame.raw <= {msdat_in, frame.raw[c_frame_bits-1:1]};  // lsb first on the wire
    end
  end

endmodule

`default_nettype wire

// File: mouse_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_init_seq import mouse_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        done,   // one acknowledged command
  output logic [8:0] cmd,    // parity in bit 8
  output logic       run     // sequence finished
);

  localparam int c_sent_bits = $clog2(c_init_len + 1);

  logic [c_sent_bits-1:0] sent;      // commands acknowledged so far
  logic [7:0]             cmd_byte;  // command before parity

  assign run = (sent == c_sent_bits'(c_init_len));

  // enable first then set rate 200, 100, 80 for the wheel mode
  always_comb begin
    case (int'(sent))
      0:       cmd_byte = c_cmd_enable;
      2:       cmd_byte = c_rate_200;
      4:       cmd_byte = c_rate_100;
      6:       cmd_byte = c_rate_80;
      default: cmd_byte = c_cmd_set_rate;  // odd steps announce a rate
    endcase
  end

  // odd parity over the data byte
  assign cmd = {~^cmd_byte, cmd_byte};

  always_ff @(posedge clk) begin
    if (reset) begin
      sent <= '0;
    end else if (done && !run) begin
      sent <= sent + 1'b1;  // next command goes out on the following request
    end
  end

endmodule

`default_nettype wire

// File: mouse_report_accum.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_report_accum import mouse_pkg::*; #(
  parameter int c_x_bits = 11,  // at least 8
  parameter int c_y_bits = 11,  // at least 8
  parameter int c_z_bits = 11   // at least 4
) (
  input  wire                 clk,
  input  wire                 done,   // report frame complete
  input  wire                 run,    // reports are valid
  input  wire  ps2_frame_t    frame,
  output logic [c_x_bits-1:0] x,
  output logic [c_y_bits-1:0] y,
  output logic [c_z_bits-1:0] z,
  output logic [2:0]          btn     // middle, right, left
);

  logic signed [8:0]    dx_raw;  // sign from byte 1 over the byte 2 value
  logic signed [8:0]    dy_raw;
  logic signed [3:0]    dz_raw;  // wheel nibble is already two's complement
  logic [c_x_bits-1:0]  dx;
  logic [c_y_bits-1:0]  dy;
  logic [c_z_bits-1:0]  dz;

  assign dx_raw = {frame.report.x_sign, frame.report.dx_byte};
  assign dy_raw = {frame.report.y_sign, frame.report.dy_byte};
  assign dz_raw = frame.report.wheel;

  // signed casts extend with the sign bit
  // an overflowed axis contributes nothing
  assign dx = frame.report.x_ovf ? '0 : c_x_bits'(dx_raw);
  assign dy = frame.report.y_ovf ? '0 : c_y_bits'(dy_raw);
  assign dz = c_z_bits'(dz_raw);

  always_ff @(posedge clk) begin
    if (!run) begin
      x   <= '0;  // held clear through reset and init
      y   <= '0;
      z   <= '0;
      btn <= '0;
    end else if (done) begin
      x   <= x + dx;  // wraps at the counter width
      y   <= y - dy;  // mouse y is up, screen y grows down
      z   <= z + dz;
      btn <= {frame.report.middle_btn, frame.report.right_btn, frame.report.left_btn};
    end
  end

endmodule

`default_nettype wire

// File: mouse_top.sv
`timescale 1ns/10ps
`default_nettype none

// ps2 mouse host with scroll wheel init
// msclk and msdat are open drain, the pad or testbench resolves them
module mouse_top import mouse_pkg::*; #(
  parameter int c_x_bits     = 11,  // at least 8
  parameter int c_y_bits     = 11,  // at least 8
  parameter int c_z_bits     = 11,  // at least 4
  parameter int c_count_bits = 15   // idle counter, 15 for 25 MHz
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 msclk_in,   // resolved clock line
  input  wire                 msdat_in,   // resolved data line
  output logic                msclk_oe,   // drive clock line low
  output logic                msdat_oe,   // drive data line low
  output logic [c_x_bits-1:0] x,
  output logic [c_y_bits-1:0] y,
  output logic [c_z_bits-1:0] z,
  output logic [2:0]          btn
);

  logic       done;   // frame closed
  logic       run;    // init done, reports flowing
  logic [8:0] cmd;    // command with parity
  ps2_frame_t frame;  // received word

  // line handling and both shifters
  ps2_line #(
    .c_count_bits (c_count_bits)
  ) u_line (
    .clk      (clk),
    .reset    (reset),
    .msclk_in (msclk_in),
    .msdat_in (msdat_in),
    .run      (run),
    .cmd      (cmd),
    .msclk_oe (msclk_oe),
    .msdat_oe (msdat_oe),
    .shift    (),
    .done     (done),
    .frame    (frame)
  );

  // steps through the seven init commands
  mouse_init_seq u_init (
    .clk   (clk),
    .reset (reset),
    .done  (done),
    .cmd   (cmd),
    .run   (run)
  );

  mouse_report_accum #(
    .c_x_bits (c_x_bits),
    .c_y_bits (c_y_bits),
    .c_z_bits (c_z_bits)
  ) u_accum (
    .clk   (clk),
    .done  (done),
    .run   (run),    // also clears the counters during init
    .frame (frame),
    .x     (x),
    .y     (y),
    .z     (z),
    .btn   (btn)
  );

endmodule

`default_nettype wire

// File: ps2_mouse_model.sv
`timescale 1ns/10ps
`default_nettype none

// behavioral ps2 mouse
// takes host commands, answers FA, then sends four-byte reports on request
module ps2_mouse_model #(
  parameter int c_half      = 16,     // ps2 clock half period in system cycles
  parameter int c_gap       = 1200,   // quiet cycles before each report
  parameter int c_init_cmds = 7,      // commands expected before reports
  parameter int c_req_limit = 4000,   // cycles to wait for a host request
  parameter int c_idle_limit = 200000 // cycles to wait for the next report
) (
  input  wire        clk,
  input  wire        msclk,      // resolved clock line
  input  wire        msdat,      // resolved data line
  output logic       clk_oe,     // pull clock low
  output logic       dat_oe,     // pull data low
  input  wire        send,       // start one report
  input  wire [31:0] report,     // byte 1 in the low bits
  output logic       ready,      // idle in report mode
  output logic       cmd_valid,  // one cycle per received command
  output logic [7:0] cmd_byte,
  output logic       cmd_par,
  output logic       cmd_stop,
  output logic       fault       // host never asked to send
);

  // everything moves a fixed delay after the system clock edge
  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // wait for the host to hold clock low, then release it with data low
  task automatic wait_request(output bit ok);
    int n;
    n = 0;
    while (msclk && n < c_req_limit) begin
      step(1);
      n++;
    end
    while (!msclk && n < c_req_limit) begin
      step(1);
      n++;
    end
    ok = (n < c_req_limit) && msclk && !msdat;
  endtask

  // clock in 8 data, parity and stop, then pull data low for the ack slot
  task automatic read_command();
    logic [9:0] bits;
    step(c_half);       // clock high for a half period before the first fall
    for (int i = 0; i < 10; i++) begin
      clk_oe = 1'b1;
      step(c_half);
      bits[i] = msdat;  // host changed data early in the low phase
      clk_oe = 1'b0;
      step(c_half);
    end
    dat_oe = 1'b1;      // line ack
    step(4);
    clk_oe = 1'b1;
    step(c_half);
    clk_oe = 1'b0;
    step(c_half);
    dat_oe = 1'b0;
    cmd_byte  = bits[7:0];
    cmd_par   = bits[8];
    cmd_stop  = bits[9];
    cmd_valid = 1'b1;
    step(1);
    cmd_valid = 1'b0;
  endtask

  // start, data lsb first, odd parity, stop
  task automatic send_byte(input logic [7:0] b);
    logic [10:0] bits;
    bits = {1'b1, ~^b, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      dat_oe = ~bits[i];  // data set while clock is high
      step(4);
      clk_oe = 1'b1;
      step(c_half);
      clk_oe = 1'b0;
      step(c_half - 4);
    end
    dat_oe = 1'b0;
  endtask

  initial begin
    logic [31:0] rpt;
    bit          ok;
    int          k;
    int          n;
    clk_oe    = 1'b0;
    dat_oe    = 1'b0;
    ready     = 1'b0;
    cmd_valid = 1'b0;
    cmd_byte  = '0;
    cmd_par   = 1'b0;
    cmd_stop  = 1'b0;
    fault     = 1'b0;
    k = 0;
    step(1);             // host registers settle on the first edge
    while (k < c_init_cmds && !fault) begin
      wait_request(ok);
      if (!ok) begin
        fault = 1'b1;
      end else begin
        read_command();
        step(10);
        send_byte(8'hFA);  // acknowledge
        k++;
      end
    end
    while (!fault) begin
      ready = 1'b1;
      n = 0;
      while (!send && n < c_idle_limit) begin
        step(1);
        n++;
      end
      if (!send) break;    // testbench stopped sending
      rpt   = report;
      ready = 1'b0;
      step(c_gap);         // host must close the previous frame first
      for (int i = 0; i < 4; i++) begin
        send_byte(rpt[8*i +: 8]);
        step(20);
      end
    end
  end

endmodule

`default_nettype wire

// File: mouse_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mouse_tb import mouse_pkg::*; ();

  localparam int c_x_bits       = 11;
  localparam int c_y_bits       = 11;
  localparam int c_z_bits       = 11;
  localparam int c_cmd_limit    = 6000;  // cycles per command incl two timeouts
  localparam int c_ready_limit  = 8000;
  localparam int c_change_limit = 3000;  // one timeout plus slack
  localparam int c_quiet        = 2000;  // wait when nothing should change
  localparam logic [7:0] c_cmd_order [7] = '{c_cmd_enable, c_cmd_set_rate, c_rate_200,
    c_cmd_set_rate, c_rate_100, c_cmd_set_rate, c_rate_80};

  logic                clk;
  logic                reset;
  logic                host_clk_oe;
  logic                host_dat_oe;
  logic                mouse_clk_oe;
  logic                mouse_dat_oe;
  wire                 msclk;
  wire                 msdat;
  logic [c_x_bits-1:0] x;
  logic [c_y_bits-1:0] y;
  logic [c_z_bits-1:0] z;
  logic [2:0]          btn;
  logic                send;
  logic [31:0]         report;
  logic                ready;
  logic                cmd_valid;
  logic [7:0]          cmd_byte;
  logic                cmd_par;
  logic                cmd_stop;
  logic                fault;

  // open drain lines with pull-ups
  assign msclk = ~(host_clk_oe | mouse_clk_oe);
  assign msdat = ~(host_dat_oe | mouse_dat_oe);

  mouse_top #(
    .c_x_bits     (c_x_bits),
    .c_y_bits     (c_y_bits),
    .c_z_bits     (c_z_bits),
    .c_count_bits (10)  // 896 cycle timeout
  ) UUT (
    .clk      (clk),
    .reset    (reset),
    .msclk_in (msclk),
    .msdat_in (msdat),
    .msclk_oe (host_clk_oe),
    .msdat_oe (host_dat_oe),
    .x        (x),
    .y        (y),
    .z        (z),
    .btn      (btn)
  );

  ps2_mouse_model mouse (
    .clk       (clk),
    .msclk     (msclk),
    .msdat     (msdat),
    .clk_oe    (mouse_clk_oe),
    .dat_oe    (mouse_dat_oe),
    .send      (send),
    .report    (report),
    .ready     (ready),
    .cmd_valid (cmd_valid),
    .cmd_byte  (cmd_byte),
    .cmd_par   (cmd_par),
    .cmd_stop  (cmd_stop),
    .fault     (fault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic tick();
    @(posedge clk);
    #1;  // drive and sample clear of the edge
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_coord(input string name, input logic [c_x_bits-1:0] exp,
                               input logic [c_x_bits-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compare_wheel(input string name, input logic [c_z_bits-1:0] exp,
                               input logic [c_z_bits-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compare_btn(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compare_cmd(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // outputs stay clear until the init sequence is done
  task automatic check_cleared();
    compare_coord("x", '0, x);
    compare_coord("y", '0, y);
    compare_wheel("z", '0, z);
    compare_btn("btn", '0, btn);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < c_ready_limit) begin
      tick();
      n++;
    end
    if (!ready) abort_run("mouse model never became ready to send a report");
  endtask

  always @(posedge clk) begin
    if (fault) abort_run("mouse model saw no request to send from host");
  end

  initial begin
    int          fd;
    int          n;
    int          count;
    int          ex;
    int          ey;
    int          ez;
    int          dx;
    int          dy;
    int          dz;
    string       line;
    logic [7:0]  v_btn;
    logic [7:0]  v_dx;
    logic [7:0]  v_dy;
    logic [7:0]  v_xo;
    logic [7:0]  v_yo;
    logic [7:0]  v_w;
    logic [2:0]  eb;
    logic [c_x_bits+c_y_bits+c_z_bits+2:0] old_out;
    reset  = 1'b1;
    send   = 1'b0;
    report = '0;
    repeat (16) tick();
    reset = 1'b0;

    for (int k = 0; k < 7; k++) begin
      n = 0;
      while (!cmd_valid && n < c_cmd_limit) begin
        tick();
        n++;
      end
      if (!cmd_valid) abort_run("no command received from host");
      compare_cmd("cmd_byte", c_cmd_order[k], cmd_byte);
      compare_bit("cmd_par", ~^c_cmd_order[k], cmd_par);  // odd parity
      compare_bit("cmd_stop", 1'b1, cmd_stop);
      check_cleared();
      tick();
    end

    fd = $fopen("mouse_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open mouse_vectors.txt");
    count = 0;
    ex = 0;
    ey = 0;
    ez = 0;
    eb = '0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h", v_btn, v_dx, v_dy, v_xo, v_yo, v_w);
      if (n != 6) abort_run("malformed line in mouse_vectors.txt");
      dx = v_dx[7] ? int'(v_dx) - 256 : int'(v_dx);      // 8 bit two's complement
      dy = v_dy[7] ? int'(v_dy) - 256 : int'(v_dy);
      dz = v_w[3] ? int'(v_w[3:0]) - 16 : int'(v_w[3:0]);  // nibble sign
      if (v_xo[0]) dx = 0;  // overflow drops the axis
      if (v_yo[0]) dy = 0;
      old_out = {x, y, z, btn};
      ex = (ex + dx) & ((1 << c_x_bits) - 1);
      ey = (ey - dy) & ((1 << c_y_bits) - 1);  // y axis flips
      ez = (ez + dz) & ((1 << c_z_bits) - 1);
      eb = v_btn[2:0];
      report = {{4{v_w[3]}}, v_w[3:0], v_dy, v_dx,
                v_yo[0], v_xo[0], v_dy[7], v_dx[7], 1'b1, v_btn[2:0]};
      wait_ready();
      send = 1'b1;
      tick();
      send = 1'b0;
      tick();
      wait_ready();  // last byte is out and done follows one timeout later
      if ({c_x_bits'(ex), c_y_bits'(ey), c_z_bits'(ez), eb} != old_out) begin
        n = 0;
        while ({x, y, z, btn} == old_out && n < c_change_limit) begin
          tick();
          n++;
        end
        if ({x, y, z, btn} == old_out) abort_run("outputs did not update after a report");
      end else begin
        repeat (c_quiet) tick();
      end
      compare_coord("x", c_x_bits'(ex), x);
      compare_coord("y", c_y_bits'(ey), y);
      compare_wheel("z", c_z_bits'(ez), z);
      compare_btn("btn", eb, btn);
      count++;
    end
    $fclose(fd);
    if (count == 0) begin
      abort_run("no reports found in mouse_vectors.txt");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mouse_vectors.txt
# columns: buttons dx dy x_ovf y_ovf wheel, all hex
# buttons bit 0 left, bit 1 right, bit 2 middle
1 05 03 0 0 0
0 10 f0 0 0 1
2 80 7f 0 0 f
2 00 00 0 0 0
4 ff 01 0 0 f
7 7f 80 0 0 f
0 00 00 0 0 0
1 ff 20 1 0 0
1 20 ff 0 1 1
0 40 40 1 1 0
0 40 40 1 1 7
3 00 00 0 0 8
3 01 ff 0 0 0
5 fe 02 0 0 f
5 fe 02 0 0 f
0 7f 7f 0 0 7
0 7f 7f 0 0 7
0 7f 7f 0 0 7
6 81 81 0 0 9
6 81 81 0 0 9
1 00 00 0 0 f
0 00 01 0 0 0
0 03 00 1 0 0
2 c0 3f 0 0 2
4 3f c0 0 0 e
0 00 00 0 0 0
7 0a f6 0 0 1
0 00 00 0 0 0

// File: list.f
mouse_pkg.sv
ps2_line.sv
mouse_init_seq.sv
mouse_report_accum.sv
mouse_top.sv
ps2_mouse_model.sv
mouse_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mouse testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module mouse_tb \
  -f list.f -o mouse_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/mouse_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }
